/* rtl/tcm_pkg.sv */
// Widths, constants and shared types of the DTCM subsystem, imported by every RTL file
package tcm_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int XLEN       = 32;   // Data word
  localparam int ICB_AW     = 16;   // Byte address on the ICB ports
  localparam int RAM_AW     = 10;   // 1024 words
  localparam int DTCM_BYTES = 4096; // First out-of-range byte address
  localparam int IRQ_NUM    = 4;

  ////////////////////////////////////////
  // Timing and depth
  ////////////////////////////////////////
  localparam int SYNC_STAGES    = 2;
  localparam int LS_IDLE_CYCLES = 8; // Idle cycles before light sleep
  localparam int RSP_DEPTH      = 2; // Responses in flight or held

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [XLEN/8-1:0] wmask_t;
  typedef logic [ICB_AW-1:0] icb_addr_t;
  typedef logic [RAM_AW-1:0] ram_addr_t;

  // Bit 0 debug, 1 external, 2 software, 3 timer
  typedef logic [IRQ_NUM-1:0] irq_vec_t;

  // Which port asked for an access
  typedef enum logic {
    SRC_LSU = 1'b0,
    SRC_EXT = 1'b1
  } src_e;

endpackage

/* rtl/tcm_ifs.sv */
// Internal DTCM links between the arbiter, the SRAM driver and the response queue
`timescale 1ns/1ns

////////////////////////////////////////
// Granted command
////////////////////////////////////////
// One-cycle issue strobe, no ready; the arbiter only issues on a free credit
interface dtcm_req_if
  import tcm_pkg::*;
();
  logic      valid;
  icb_addr_t addr;
  logic      read;
  xlen_t     wdata;
  wmask_t    wmask;
  src_e      src;   // Port that won arbitration

  modport arb (
    output valid, addr, read, wdata, wmask, src
  );

  modport ram (
    input valid, addr, read, wdata, wmask, src
  );
endinterface

////////////////////////////////////////
// Access record
////////////////////////////////////////
// Sent in the issue cycle, the response side lines it up with SRAM data
interface dtcm_tag_if
  import tcm_pkg::*;
();
  logic valid;
  src_e src;
  logic read;
  logic err;   // Address outside the DTCM

  modport ram (
    output valid, src, read, err
  );

  modport rsp (
    input valid, src, read, err
  );
endinterface

/* rtl/dtcm_arbiter.sv */
// Round-robin arbiter that grants the lsu or ext ICB command port to the DTCM SRAM
`timescale 1ns/1ns

module dtcm_arbiter
  import tcm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Core load/store port
  input  logic      lsu_cmd_valid,
  output logic      lsu_cmd_ready,
  input  icb_addr_t lsu_cmd_addr,
  input  logic      lsu_cmd_read,
  input  xlen_t     lsu_cmd_wdata,
  input  wmask_t    lsu_cmd_wmask,

  // External agent port
  input  logic      ext_cmd_valid,
  output logic      ext_cmd_ready,
  input  icb_addr_t ext_cmd_addr,
  input  logic      ext_cmd_read,
  input  xlen_t     ext_cmd_wdata,
  input  wmask_t    ext_cmd_wmask,

  input  logic      rsp_free,  // Response credit available
  input  logic      dtcm_ls,   // Memory in light sleep

  dtcm_req_if.arb   req
);

  src_e last_gnt;   // Port served by the previous issue
  logic can_issue;
  logic gnt_lsu;
  logic gnt_ext;
  logic issue;

  assign can_issue = rsp_free && !dtcm_ls;

  // A lone requester wins, a tie goes to the port not served last
  assign gnt_lsu = lsu_cmd_valid && (!ext_cmd_valid || (last_gnt == SRC_EXT));
  assign gnt_ext = ext_cmd_valid && (!lsu_cmd_valid || (last_gnt == SRC_LSU));

  assign lsu_cmd_ready = can_issue && gnt_lsu;
  assign ext_cmd_ready = can_issue && gnt_ext;
  assign issue         = lsu_cmd_ready || ext_cmd_ready;

  ////////////////////////////////////////
  // Command mux
  ////////////////////////////////////////
  always_comb begin
    req.valid = issue;
    if (gnt_ext) begin
      req.src   = SRC_EXT;
      req.addr  = ext_cmd_addr;
      req.read  = ext_cmd_read;
      req.wdata = ext_cmd_wdata;
      req.wmask = ext_cmd_wmask;
    end else begin
      req.src   = SRC_LSU;
      req.addr  = lsu_cmd_addr;
      req.read  = lsu_cmd_read;
      req.wdata = lsu_cmd_wdata;
      req.wmask = lsu_cmd_wmask;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_gnt <= SRC_EXT;  // lsu takes the first tie
    end else if (issue) begin
      last_gnt <= gnt_ext ? SRC_EXT : SRC_LSU;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  assert property (@(posedge clk) disable iff (!rst_n)
    !(lsu_cmd_ready && ext_cmd_ready));

endmodule

/* rtl/dtcm_ram_if.sv */
// Turns the granted DTCM command into SRAM strobes and flags out-of-range addresses
`timescale 1ns/1ns

module dtcm_ram_if
  import tcm_pkg::*;
(
  dtcm_req_if.ram   req,
  dtcm_tag_if.ram   tag,

  // Single-port SRAM, sampled at the acceptance edge
  output logic      ram_cs,
  output logic      ram_we,
  output ram_addr_t ram_addr,
  output wmask_t    ram_wem,
  output xlen_t     ram_din
);

  logic in_range;

  ////////////////////////////////////////
  // Address check
  ////////////////////////////////////////
  // DTCM sits at byte 0 up to DTCM_BYTES-1
  assign in_range = req.addr < ICB_AW'(DTCM_BYTES);

  ////////////////////////////////////////
  // SRAM strobes
  ////////////////////////////////////////
  // No access at all for an out-of-range command
  assign ram_cs   = req.valid && in_range;
  assign ram_we   = ram_cs && !req.read;
  assign ram_addr = req.addr[RAM_AW+1:2];         // Byte to word address
  assign ram_wem  = ram_we ? req.wmask : '0;
  assign ram_din  = req.wdata;

  ////////////////////////////////////////
  // Access record for the response side
  ////////////////////////////////////////
  assign tag.valid = req.valid;
  assign tag.src   = req.src;
  assign tag.read  = req.read;
  assign tag.err   = req.valid && !in_range;  // Reported back as rsp_err

endmodule

/* rtl/dtcm_rsp_buf.sv */
// Captures SRAM read data, queues DTCM responses in order and routes each to its port
`timescale 1ns/1ns

module dtcm_rsp_buf
  import tcm_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  dtcm_tag_if.rsp tag,
  input  xlen_t   ram_dout,

  output logic    rsp_free,   // Room for one more issue

  output logic    lsu_rsp_valid,
  input  logic    lsu_rsp_ready,
  output logic    lsu_rsp_err,
  output xlen_t   lsu_rsp_rdata,

  output logic    ext_rsp_valid,
  input  logic    ext_rsp_ready,
  output logic    ext_rsp_err,
  output xlen_t   ext_rsp_rdata
);

  // Tag stage, one cycle behind the issue to meet dout
  logic tag_q_valid;
  src_e tag_q_src;
  logic tag_q_read;
  logic tag_q_err;

  // In-order response queue
  src_e  q_src  [RSP_DEPTH];
  logic  q_err  [RSP_DEPTH];
  xlen_t q_data [RSP_DEPTH];
  logic [$clog2(RSP_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(RSP_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(RSP_DEPTH+1)-1:0] held_cnt;
  logic  head_valid;
  logic  pop;
  xlen_t push_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_q_valid <= 1'b0;
    end else begin
      tag_q_valid <= tag.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      tag_q_src  <= tag.src;
      tag_q_read <= tag.read;
      tag_q_err  <= tag.err;
    end
  end

  // Writes and errors return zero data
  assign push_data = (tag_q_read && !tag_q_err) ? ram_dout : '0;

  ////////////////////////////////////////
  // Queue storage and pointers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tag_q_valid) begin
      q_src[wr_ptr]  <= tag_q_src;
      q_err[wr_ptr]  <= tag_q_err;
      q_data[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      held_cnt <= '0;
    end else begin
      if (tag_q_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({tag_q_valid, pop})
        2'b10:   held_cnt <= held_cnt + 1'b1;
        2'b01:   held_cnt <= held_cnt - 1'b1;
        default: held_cnt <= held_cnt;
      endcase
    end
  end

  // In flight plus held
  assign rsp_free = (int'(held_cnt) + int'(tag_q_valid)) < RSP_DEPTH;

  ////////////////////////////////////////
  // Head routing
  ////////////////////////////////////////
  assign head_valid    = held_cnt != '0;
  assign lsu_rsp_valid = head_valid && (q_src[rd_ptr] == SRC_LSU);
  assign ext_rsp_valid = head_valid && (q_src[rd_ptr] == SRC_EXT);
  assign lsu_rsp_err   = q_err[rd_ptr];
  assign ext_rsp_err   = q_err[rd_ptr];
  assign lsu_rsp_rdata = q_data[rd_ptr];
  assign ext_rsp_rdata = q_data[rd_ptr];
  assign pop = (lsu_rsp_valid && lsu_rsp_ready) || (ext_rsp_valid && ext_rsp_ready);

  // The arbiter credit check must keep the queue from overflowing
  assert property (@(posedge clk) disable iff (!rst_n)
    tag_q_valid && !pop |-> int'(held_cnt) < RSP_DEPTH);

  assert property (@(posedge clk) disable iff (!rst_n)
    lsu_rsp_valid && !lsu_rsp_ready
    |=> lsu_rsp_valid && $stable(lsu_rsp_rdata) && $stable(lsu_rsp_err));

  assert property (@(posedge clk) disable iff (!rst_n)
    ext_rsp_valid && !ext_rsp_ready
    |=> ext_rsp_valid && $stable(ext_rsp_rdata) && $stable(ext_rsp_err));

endmodule

/* rtl/aon_ctrl.sv */
// Always-on control with interrupt synchronizers and the DTCM light-sleep idle counter
`timescale 1ns/1ns

module aon_ctrl
  import tcm_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  irq_vec_t irq_a,     // Asynchronous interrupt lines
  output irq_vec_t irq_r,

  input  logic     lsu_cmd_valid,
  input  logic     ext_cmd_valid,
  input  logic     rsp_free,
  output logic     dtcm_ls
);

  irq_vec_t sync_q [SYNC_STAGES];
  logic [$clog2(LS_IDLE_CYCLES+1)-1:0] idle_cnt;
  logic idle;

  ////////////////////////////////////////
  // Interrupt synchronizers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= irq_a;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign irq_r = sync_q[SYNC_STAGES-1];

  ////////////////////////////////////////
  // Light-sleep idle counter
  ////////////////////////////////////////
  // No request on either port and no credit shortage
  assign idle = !lsu_cmd_valid && !ext_cmd_valid && rsp_free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_cnt <= '0;
    end else if (!idle) begin
      idle_cnt <= '0;  // Any request wakes the memory
    end else if (int'(idle_cnt) < LS_IDLE_CYCLES) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  assign dtcm_ls = int'(idle_cnt) == LS_IDLE_CYCLES;  // Saturated count

endmodule

/* rtl/cpu_tcm_top.sv */
// DTCM subsystem top with two ICB ports, the SRAM pins, light sleep and synchronized IRQs
`timescale 1ns/1ns

module cpu_tcm_top
  import tcm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Core load/store ICB
  input  logic      lsu_cmd_valid,
  output logic      lsu_cmd_ready,
  input  icb_addr_t lsu_cmd_addr,
  input  logic      lsu_cmd_read,
  input  xlen_t     lsu_cmd_wdata,
  input  wmask_t    lsu_cmd_wmask,
  output logic      lsu_rsp_valid,
  input  logic      lsu_rsp_ready,
  output logic      lsu_rsp_err,
  output xlen_t     lsu_rsp_rdata,

  // External agent ICB
  input  logic      ext_cmd_valid,
  output logic      ext_cmd_ready,
  input  icb_addr_t ext_cmd_addr,
  input  logic      ext_cmd_read,
  input  xlen_t     ext_cmd_wdata,
  input  wmask_t    ext_cmd_wmask,
  output logic      ext_rsp_valid,
  input  logic      ext_rsp_ready,
  output logic      ext_rsp_err,
  output xlen_t     ext_rsp_rdata,

  // Interrupts
  input  irq_vec_t  irq_a,
  output irq_vec_t  irq_r,

  // DTCM SRAM, kept outside
  output logic      dtcm_ls,
  output logic      ram_cs,
  output logic      ram_we,
  output ram_addr_t ram_addr,
  output wmask_t    ram_wem,
  output xlen_t     ram_din,
  input  xlen_t     ram_dout
);

  logic rsp_free;

  dtcm_req_if req_if ();
  dtcm_tag_if tag_if ();

  ////////////////////////////////////////
  // Command path
  ////////////////////////////////////////
  dtcm_arbiter u_dtcm_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd_addr  (lsu_cmd_addr),
    .lsu_cmd_read  (lsu_cmd_read),
    .lsu_cmd_wdata (lsu_cmd_wdata),
    .lsu_cmd_wmask (lsu_cmd_wmask),
    .ext_cmd_valid (ext_cmd_valid),
    .ext_cmd_ready (ext_cmd_ready),
    .ext_cmd_addr  (ext_cmd_addr),
    .ext_cmd_read  (ext_cmd_read),
    .ext_cmd_wdata (ext_cmd_wdata),
    .ext_cmd_wmask (ext_cmd_wmask),
    .rsp_free      (rsp_free),
    .dtcm_ls       (dtcm_ls),
    .req           (req_if.arb)
  );

  dtcm_ram_if u_dtcm_ram_if (
    .req      (req_if.ram),
    .tag      (tag_if.ram),
    .ram_cs   (ram_cs),
    .ram_we   (ram_we),
    .ram_addr (ram_addr),
    .ram_wem  (ram_wem),
    .ram_din  (ram_din)
  );

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////
  dtcm_rsp_buf u_dtcm_rsp_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .tag           (tag_if.rsp),
    .ram_dout      (ram_dout),
    .rsp_free      (rsp_free),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp_err   (lsu_rsp_err),
    .lsu_rsp_rdata (lsu_rsp_rdata),
    .ext_rsp_valid (ext_rsp_valid),
    .ext_rsp_ready (ext_rsp_ready),
    .ext_rsp_err   (ext_rsp_err),
    .ext_rsp_rdata (ext_rsp_rdata)
  );

  aon_ctrl u_aon_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_a         (irq_a),
    .irq_r         (irq_r),
    .lsu_cmd_valid (lsu_cmd_valid),
    .ext_cmd_valid (ext_cmd_valid),
    .rsp_free      (rsp_free),
    .dtcm_ls       (dtcm_ls)
  );

endmodule

/* include/tb_checks.svh */
// Compare tasks, error counters and the DTCM SRAM model, included inside the testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned chk_cnt = 0;
int unsigned err_cnt = 0;

// Behavioral DTCM storage
xlen_t sram_mem [2**RAM_AW];

task automatic check_data(input string what, input xlen_t got, input xlen_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s: got %h, expected %h", what, got, exp);
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s: got %h, expected %h", what, got, exp);
  end
endtask

task automatic check_irq(input string what, input irq_vec_t got, input irq_vec_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s: got %h, expected %h", what, got, exp);
  end
endtask

function automatic void sram_clear();
  foreach (sram_mem[i]) begin
    sram_mem[i] = '0;
  end
endfunction

// One SRAM clock edge; the result is the next dout, held when not reading
function automatic xlen_t sram_access(input logic cs, input logic we, input ram_addr_t addr,
                                      input wmask_t wem, input xlen_t din, input xlen_t dout);
  xlen_t word;
  word = sram_mem[addr];
  if (cs && we) begin
    for (int b = 0; b < XLEN/8; b++) begin
      if (wem[b]) begin
        word[8*b +: 8] = din[8*b +: 8];
      end
    end
    sram_mem[addr] = word;
    return dout;
  end
  return cs ? word : dout;
endfunction

`endif

/* verification/tb_cpu_tcm_top.sv */
// Directed testbench for the DTCM subsystem top, run as the simulation top level
`timescale 1ns/1ns

module tb_cpu_tcm_top
  import tcm_pkg::*;
();

  localparam int CMD_TIMEOUT = 200;   // Cycles a port may wait on a handshake
  localparam int TEST_CYCLES = 400;   // Rough sum of all test lengths
  localparam int WATCHDOG_NS = TEST_CYCLES * 8 + 2000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read;
  icb_addr_t lsu_cmd_addr;
  xlen_t     lsu_cmd_wdata, lsu_rsp_rdata;
  wmask_t    lsu_cmd_wmask;
  logic      lsu_rsp_valid, lsu_rsp_ready, lsu_rsp_err;
  logic      ext_cmd_valid, ext_cmd_ready, ext_cmd_read;
  icb_addr_t ext_cmd_addr;
  xlen_t     ext_cmd_wdata, ext_rsp_rdata;
  wmask_t    ext_cmd_wmask;
  logic      ext_rsp_valid, ext_rsp_ready, ext_rsp_err;
  irq_vec_t  irq_a, irq_r;
  logic      dtcm_ls, ram_cs, ram_we;
  ram_addr_t ram_addr;
  wmask_t    ram_wem;
  xlen_t     ram_din;
  xlen_t     ram_dout = '0;

  `include "tb_checks.svh"

  int    seed = 32'hc015_4a9d;
  xlen_t ref_mem [2**RAM_AW];          // Expected DTCM contents
  xlen_t exp_data_lsu [$];
  xlen_t exp_data_ext [$];
  logic  exp_err_lsu [$];
  logic  exp_err_ext [$];
  src_e  acc_log [$];                  // Ports in acceptance order
  src_e  last_src = SRC_EXT;

  cpu_tcm_top uut (.*);

  always #4 clk = ~clk;

  // External SRAM, one access per rising edge
  always @(posedge clk) begin
    ram_dout <= sram_access(ram_cs, ram_we, ram_addr, ram_wem, ram_din, ram_dout);
  end

  ////////////////////////////////////////
  // Port drivers
  ////////////////////////////////////////
  task automatic drive_cmd(input src_e src, input logic v, input icb_addr_t a,
                           input logic rd, input xlen_t wd, input wmask_t wm);
    if (src == SRC_LSU) begin
      lsu_cmd_valid = v;
      lsu_cmd_addr  = a;
      lsu_cmd_read  = rd;
      lsu_cmd_wdata = wd;
      lsu_cmd_wmask = wm;
    end else begin
      ext_cmd_valid = v;
      ext_cmd_addr  = a;
      ext_cmd_read  = rd;
      ext_cmd_wdata = wd;
      ext_cmd_wmask = wm;
    end
  endtask

  // Update the expected memory and queue the expected response
  task automatic record_accept(input src_e src, input icb_addr_t a, input logic rd,
                               input xlen_t wd, input wmask_t wm, input logic tie);
    logic  err;
    xlen_t word;
    int    idx;
    err = a >= DTCM_BYTES;
    idx = int'(a[RAM_AW+1:2]);
    word = ref_mem[idx];
    if (!err && !rd) begin
      for (int b = 0; b < 4; b++) begin
        if (wm[b]) word[8*b +: 8] = wd[8*b +: 8];
      end
      ref_mem[idx] = word;
    end
    if (tie) check_bit("tie winner alternates", src != last_src, 1'b1);
    last_src = src;
    acc_log.push_back(src);
    if (src == SRC_LSU) begin
      exp_data_lsu.push_back((rd && !err) ? word : '0);
      exp_err_lsu.push_back(err);
    end else begin
      exp_data_ext.push_back((rd && !err) ? word : '0);
      exp_err_ext.push_back(err);
    end
  endtask

  // Offer one command and return after the accepting edge, valid left high
  task automatic do_cmd(input src_e src, input icb_addr_t a, input logic rd,
                        input xlen_t wd, input wmask_t wm);
    logic rdy;
    logic other;
    int   waited;
    rdy = 1'b0;
    waited = 0;
    @(negedge clk);
    drive_cmd(src, 1'b1, a, rd, wd, wm);
    while (!rdy && waited < CMD_TIMEOUT) begin
      #1;
      rdy   = (src == SRC_LSU) ? lsu_cmd_ready : ext_cmd_ready;
      other = (src == SRC_LSU) ? ext_cmd_valid : lsu_cmd_valid;
      if (rdy) record_accept(src, a, rd, wd, wm, other);
      @(posedge clk);
      if (!rdy) begin
        waited++;
        @(negedge clk);
      end
    end
    if (!rdy) begin
      err_cnt++;
      $display("Command on port %s was never accepted", src.name());
    end
  endtask

  task automatic release_cmd(input src_e src);
    @(negedge clk);
    drive_cmd(src, 1'b0, '0, 1'b0, '0, '0);
  endtask

  // Take one response and compare it with the oldest expected one
  task automatic get_rsp(input src_e src);
    logic  v;
    logic  err;
    xlen_t data;
    int    waited;
    src_e  exp_src;
    v = 1'b0;
    waited = 0;
    @(negedge clk);
    if (src == SRC_LSU) lsu_rsp_ready = 1'b1;
    else ext_rsp_ready = 1'b1;
    while (!v && waited < CMD_TIMEOUT) begin
      #1;
      v    = (src == SRC_LSU) ? lsu_rsp_valid : ext_rsp_valid;
      err  = (src == SRC_LSU) ? lsu_rsp_err : ext_rsp_err;
      data = (src == SRC_LSU) ? lsu_rsp_rdata : ext_rsp_rdata;
      @(posedge clk);
      if (!v) begin
        waited++;
        @(negedge clk);
      end
    end
    @(negedge clk);
    if (src == SRC_LSU) lsu_rsp_ready = 1'b0;
    else ext_rsp_ready = 1'b0;
    if (!v) begin
      err_cnt++;
      $display("No response arrived on port %s", src.name());
    end else begin
      exp_src = acc_log.pop_front();
      check_bit("response in acceptance order", exp_src == src, 1'b1);
      if (src == SRC_LSU) begin
        check_data("lsu_rsp_rdata", data, exp_data_lsu.pop_front());
        check_bit("lsu_rsp_err", err, exp_err_lsu.pop_front());
      end else begin
        check_data("ext_rsp_rdata", data, exp_data_ext.pop_front());
        check_bit("ext_rsp_err", err, exp_err_ext.pop_front());
      end
    end
  endtask

  task automatic access(input src_e src, input icb_addr_t a, input logic rd,
                        input xlen_t wd, input wmask_t wm);
    do_cmd(src, a, rd, wd, wm);
    release_cmd(src);
    get_rsp(src);
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    if (err_cnt == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic lsu_write_read();
    int unsigned e0;
    e0 = err_cnt;
    access(SRC_LSU, 16'h0040, 1'b0, $random(seed), 4'hf);
    access(SRC_LSU, 16'h0040, 1'b1, '0, '0);
    access(SRC_LSU, 16'h0040, 1'b0, $random(seed), 4'b0101);  // Bytes 1 and 3 kept
    access(SRC_LSU, 16'h0040, 1'b1, '0, '0);
    end_test("lsu write and read", e0);
  endtask

  task automatic cross_port_access();
    int unsigned e0;
    e0 = err_cnt;
    access(SRC_EXT, 16'h0100, 1'b0, $random(seed), 4'hf);
    access(SRC_LSU, 16'h0100, 1'b1, '0, '0);
    access(SRC_LSU, 16'h0ffc, 1'b0, $random(seed), 4'hf);
    access(SRC_EXT, 16'h0ffc, 1'b1, '0, '0);
    end_test("cross-port visibility", e0);
  endtask

  task automatic port_stream(input src_e src, input int n);
    for (int i = 0; i < n; i++) begin
      do_cmd(src, icb_addr_t'(($random(seed) & 32'hf) << 2), 1'($random(seed)),
             $random(seed), 4'hf);
    end
    release_cmd(src);
  endtask

  task automatic port_collect(input src_e src, input int n);
    for (int i = 0; i < n; i++) begin
      get_rsp(src);
    end
  endtask

  task automatic tie_arbitration();
    int unsigned e0;
    e0 = err_cnt;
    fork
      port_stream(SRC_LSU, 8);
      port_stream(SRC_EXT, 8);
      port_collect(SRC_LSU, 8);
      port_collect(SRC_EXT, 8);
    join
    end_test("arbitration", e0);
  endtask

  task automatic range_error();
    int unsigned e0;
    e0 = err_cnt;
    access(SRC_LSU, 16'h0000, 1'b0, $random(seed), 4'hf);
    access(SRC_LSU, 16'h1000, 1'b0, $random(seed), 4'hf);  // Aliases word 0 if decoded
    access(SRC_EXT, 16'h1000, 1'b1, '0, '0);
    access(SRC_LSU, 16'h0000, 1'b1, '0, '0);
    end_test("out-of-range access", e0);
  endtask

  task automatic response_backpressure();
    int unsigned e0;
    int accepted;
    e0 = err_cnt;
    accepted = 0;
    access(SRC_LSU, 16'h0200, 1'b0, $random(seed), 4'hf);
    access(SRC_LSU, 16'h0204, 1'b0, $random(seed), 4'hf);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      drive_cmd(SRC_LSU, 1'b1, (accepted == 0) ? 16'h0200 : 16'h0204, 1'b1, '0, '0);
      #1;
      if (lsu_cmd_ready) begin
        record_accept(SRC_LSU, lsu_cmd_addr, 1'b1, '0, '0, ext_cmd_valid);
        accepted++;
      end
      @(posedge clk);
    end
    release_cmd(SRC_LSU);
    check_data("accepted command count", xlen_t'(accepted), 32'd2);
    repeat (3) begin
      @(negedge clk);
      #1;
      check_bit("lsu_rsp_valid", lsu_rsp_valid, 1'b1);
      check_data("lsu_rsp_rdata", lsu_rsp_rdata, exp_data_lsu[0]);
    end
    get_rsp(SRC_LSU);
    get_rsp(SRC_LSU);
    end_test("response back-pressure", e0);
  endtask

  task automatic irq_sync_sleep();
    int unsigned e0;
    e0 = err_cnt;
    @(negedge clk);
    irq_a = 4'b1010;
    @(posedge clk);
    #1;
    check_irq("irq_r after one edge", irq_r, 4'b0000);
    @(posedge clk);
    #1;
    check_irq("irq_r after two edges", irq_r, 4'b1010);
    repeat (LS_IDLE_CYCLES + 2) @(posedge clk);
    #1;
    check_bit("dtcm_ls when idle", dtcm_ls, 1'b1);
    access(SRC_LSU, 16'h0100, 1'b1, '0, '0);
    check_bit("dtcm_ls after read", dtcm_ls, 1'b0);
    end_test("irq sync and light sleep", e0);
  endtask

  ////////////////////////////////////////
  // Run
  ////////////////////////////////////////
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    drive_cmd(SRC_LSU, 1'b0, '0, 1'b0, '0, '0);
    drive_cmd(SRC_EXT, 1'b0, '0, 1'b0, '0, '0);
    lsu_rsp_ready = 1'b0;
    ext_rsp_ready = 1'b0;
    irq_a = '0;
    sram_clear();
    foreach (ref_mem[i]) ref_mem[i] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    lsu_write_read();
    cross_port_access();
    tie_arbitration();
    range_error();
    response_backpressure();
    irq_sync_sleep();
    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
rtl/tcm_pkg.sv
rtl/tcm_ifs.sv
rtl/dtcm_arbiter.sv
rtl/dtcm_ram_if.sv
rtl/dtcm_rsp_buf.sv
rtl/aon_ctrl.sv
rtl/cpu_tcm_top.sv
verification/tb_cpu_tcm_top.sv

/* Makefile */
TOP := tb_cpu_tcm_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
